// File: fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// fetch address width
`define FETCH_ADDR_W 32

// instruction word width
`define FETCH_WORD_W 32

// cache geometry
// bytes per line, power of two
`define FETCH_LINE_BYTES 16

// direct-mapped, one line per index
`define FETCH_NUM_LINES 8

// first fetch address out of reset
`define FETCH_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

`endif

// File: fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

    // address split: | tag | index | offset |
    localparam int OFFSET_W = $clog2(`FETCH_LINE_BYTES);
    localparam int INDEX_W = $clog2(`FETCH_NUM_LINES);
    localparam int TAG_W = `FETCH_ADDR_W - INDEX_W - OFFSET_W;

    // address of a whole line, offset dropped
    localparam int LINE_ADDR_W = `FETCH_ADDR_W - OFFSET_W;

    // words inside one line
    localparam int WORD_BYTES = `FETCH_WORD_W / 8;
    localparam int WORD_SEL_W = $clog2(`FETCH_LINE_BYTES / WORD_BYTES);

    // one line, byte 0 in the low bits
    typedef logic [`FETCH_LINE_BYTES-1:0][7:0] cache_line_t;

    typedef logic [TAG_W-1:0] tag_t;

    typedef logic [INDEX_W-1:0] index_t;

    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

    // register selector of the control block
    typedef enum logic [1:0] {
        CTRL     = 2'd0,
        HIT_CNT  = 2'd1,
        MISS_CNT = 2'd2
    } csr_addr_e;

endpackage

// File: fetch_ifs.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

// pc unit <-> icache lookup port
// word is taken at the edge where req and hit are both high
interface fetch_lookup_if;
    logic                     lookup_req;
    logic [`FETCH_ADDR_W-1:0] lookup_addr;
    logic                     lookup_hit;
    logic [`FETCH_WORD_W-1:0] lookup_instr;

    modport pc (output lookup_req, output lookup_addr, input lookup_hit, input lookup_instr);

    modport cache (input lookup_req, input lookup_addr, output lookup_hit, output lookup_instr);
endinterface

// control block <-> icache steering
// flush, hit_evt, miss_evt are single-cycle pulses
interface cache_ctl_if;
    logic cache_en;
    logic flush;
    logic hit_evt;
    logic miss_evt;

    modport csr (output cache_en, output flush, input hit_evt, input miss_evt);

    modport cache (input cache_en, input flush, output hit_evt, output miss_evt);
endinterface

// File: cache_array.sv
`timescale 1ns/1ns

// storage for tags or line data
// write at the clock edge, read straight from the address
module cache_array #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH = 8
) (
    input  logic                     clk_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  payload_t                 wdata_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output payload_t                 rdata_o
);

    // one entry per cache index
    payload_t mem_q [DEPTH];

    // refill port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // lookup port, same cycle as the address
    assign rdata_o = mem_q[raddr_i];

endmodule

// File: icache.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module icache (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    fetch_lookup_if.cache            lookup,
    cache_ctl_if.cache               ctl,
    output logic                     mem_rd_o,
    output logic [`FETCH_ADDR_W-1:0] mem_addr_o,
    input  logic                     mem_ready_i,
    input  fetch_pkg::cache_line_t   mem_line_i
);

    // lookup address fields
    fetch_pkg::line_addr_t lk_laddr;
    fetch_pkg::tag_t lk_tag;
    fetch_pkg::index_t lk_idx;
    logic [fetch_pkg::WORD_SEL_W-1:0] lk_word;

    // line being refilled
    fetch_pkg::line_addr_t miss_laddr;
    fetch_pkg::tag_t miss_tag;
    fetch_pkg::index_t miss_idx;

    // array read side
    fetch_pkg::tag_t rd_tag;
    fetch_pkg::cache_line_t rd_line;
    fetch_pkg::cache_line_t sel_line;

    // one-line buffer used while the cache is off
    logic byp_valid_q;
    fetch_pkg::line_addr_t byp_laddr_q;
    fetch_pkg::cache_line_t byp_line_q;

    logic [`FETCH_NUM_LINES-1:0] valid_q;
    logic refill_q;
    logic fill_pending_q;
    logic start_miss;
    logic fill;
    logic array_we;
    logic cache_hit;
    logic byp_hit;

    assign lk_laddr = lookup.lookup_addr[`FETCH_ADDR_W-1:fetch_pkg::OFFSET_W];
    assign lk_tag = lk_laddr[fetch_pkg::LINE_ADDR_W-1:fetch_pkg::INDEX_W];
    assign lk_idx = lk_laddr[fetch_pkg::INDEX_W-1:0];
    assign lk_word =
        lookup.lookup_addr[fetch_pkg::OFFSET_W-1:fetch_pkg::OFFSET_W-fetch_pkg::WORD_SEL_W];

    assign miss_tag = miss_laddr[fetch_pkg::LINE_ADDR_W-1:fetch_pkg::INDEX_W];
    assign miss_idx = miss_laddr[fetch_pkg::INDEX_W-1:0];

    // ready pulse closes the refill
    assign fill = refill_q && mem_ready_i;
    // no allocation with the cache off
    assign array_we = fill && ctl.cache_en;

    cache_array #(
        .payload_t(fetch_pkg::tag_t),
        .DEPTH    (`FETCH_NUM_LINES)
    ) i_tag_array (
        .clk_i  (clk_i),
        .we_i   (array_we),
        .waddr_i(miss_idx),
        .wdata_i(miss_tag),
        .raddr_i(lk_idx),
        .rdata_o(rd_tag)
    );

    cache_array #(
        .payload_t(fetch_pkg::cache_line_t),
        .DEPTH    (`FETCH_NUM_LINES)
    ) i_data_array (
        .clk_i  (clk_i),
        .we_i   (array_we),
        .waddr_i(miss_idx),
        .wdata_i(mem_line_i),
        .raddr_i(lk_idx),
        .rdata_o(rd_line)
    );

    // hit detection, flush cycle never hits
    assign cache_hit = valid_q[lk_idx] && (rd_tag == lk_tag);
    assign byp_hit = byp_valid_q && (byp_laddr_q == lk_laddr);
    assign lookup.lookup_hit = !ctl.flush && (ctl.cache_en ? cache_hit : byp_hit);

    // word select by offset
    assign sel_line = ctl.cache_en ? rd_line : byp_line_q;
    assign lookup.lookup_instr =
        sel_line[lk_word*fetch_pkg::WORD_BYTES +: fetch_pkg::WORD_BYTES];

    // first missing cycle, only from idle
    assign start_miss = !refill_q && lookup.lookup_req && !lookup.lookup_hit;

    // read level, from the miss until the ready pulse
    assign mem_rd_o = start_miss || refill_q;
    assign mem_addr_o = refill_q ? {miss_laddr, {fetch_pkg::OFFSET_W{1'b0}}}
                                 : {lk_laddr, {fetch_pkg::OFFSET_W{1'b0}}};

    assign ctl.miss_evt = start_miss;
    // the lookup right after a fill completes the counted miss, not a new hit
    assign ctl.hit_evt = lookup.lookup_req && lookup.lookup_hit && !fill_pending_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            refill_q <= 1'b0;
            fill_pending_q <= 1'b0;
        end else begin
            if (start_miss) begin
                refill_q <= 1'b1;
            end else if (fill) begin
                refill_q <= 1'b0;
            end
            // cleared by the next lookup, hit or not
            if (fill) begin
                fill_pending_q <= 1'b1;
            end else if (lookup.lookup_req) begin
                fill_pending_q <= 1'b0;
            end
        end
    end

    // valid bits, flush wins over a fill
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            byp_valid_q <= 1'b0;
        end else if (ctl.flush) begin
            valid_q <= '0;
            byp_valid_q <= 1'b0;
        end else if (fill) begin
            if (ctl.cache_en) begin
                valid_q[miss_idx] <= 1'b1;
            end else begin
                byp_valid_q <= 1'b1;
            end
        end
    end

    // miss address and bypass payload
    always_ff @(posedge clk_i) begin
        if (start_miss) begin
            miss_laddr <= lk_laddr;
        end
        if (fill && !ctl.cache_en) begin
            byp_laddr_q <= miss_laddr;
            byp_line_q <= mem_line_i;
        end
    end

    // line address holds for the whole request
    a_miss_addr_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_rd_o && !mem_ready_i |=> $stable(mem_addr_o));

    // memory answers only an open request
    a_ready_needs_rd : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_ready_i |-> mem_rd_o);

endmodule

// File: fetch_pc.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_pc (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     block_if_i,
    input  logic                     inject_nops_i,
    input  logic                     tkbr_i,
    input  logic [`FETCH_ADDR_W-1:0] new_pc_i,
    fetch_lookup_if.pc               lookup,
    output logic                     valid_o,
    output logic [`FETCH_WORD_W-1:0] instr_o,
    output logic [`FETCH_ADDR_W-1:0] pc_o
);

    logic [`FETCH_ADDR_W-1:0] pc_q;
    logic take_hit;

    // no lookup while blocked, redirected or injecting
    assign lookup.lookup_req = !(block_if_i || tkbr_i || inject_nops_i);
    assign lookup.lookup_addr = pc_q;

    // word taken at this edge
    assign take_hit = lookup.lookup_req && lookup.lookup_hit;

    // pc and valid
    // priority: branch, block, inject, hit
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `FETCH_RESET_PC;
            valid_o <= 1'b0;
        end else if (tkbr_i) begin
            // in-flight word dropped
            pc_q <= new_pc_i;
            valid_o <= 1'b0;
        end else if (block_if_i) begin
            valid_o <= 1'b0;
        end else if (inject_nops_i) begin
            // pc stays, nop goes out
            valid_o <= 1'b1;
        end else if (take_hit) begin
            pc_q <= pc_q + `FETCH_ADDR_W'(fetch_pkg::WORD_BYTES);
            valid_o <= 1'b1;
        end else begin
            // miss, wait for refill
            valid_o <= 1'b0;
        end
    end

    // word and pc toward decode
    // hold when nothing new is taken
    always_ff @(posedge clk_i) begin
        if (inject_nops_i && !tkbr_i && !block_if_i) begin
            instr_o <= `FETCH_NOP;
            pc_o <= pc_q;
        end else if (take_hit) begin
            instr_o <= lookup.lookup_instr;
            pc_o <= pc_q;
        end
    end

endmodule

// File: fetch_csr.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_csr (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     csr_we_i,
    input  fetch_pkg::csr_addr_e     csr_addr_i,
    input  logic [`FETCH_WORD_W-1:0] csr_wdata_i,
    output logic [`FETCH_WORD_W-1:0] csr_rdata_o,
    cache_ctl_if.csr                 ctl
);

    logic ctrl_we;
    logic cnt_clr;
    logic en_q;
    logic flush_q;
    logic [`FETCH_WORD_W-1:0] hit_cnt_q;
    logic [`FETCH_WORD_W-1:0] miss_cnt_q;

    // ctrl: bit0 enable, bit1 flush, bit2 counter clear
    assign ctrl_we = csr_we_i && (csr_addr_i == fetch_pkg::CTRL);
    assign cnt_clr = ctrl_we && csr_wdata_i[2];

    assign ctl.cache_en = en_q;
    assign ctl.flush = flush_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q <= 1'b1;
            flush_q <= 1'b0;
            hit_cnt_q <= '0;
            miss_cnt_q <= '0;
        end else begin
            if (ctrl_we) begin
                en_q <= csr_wdata_i[0];
            end
            // single-cycle pulse per write
            flush_q <= ctrl_we && csr_wdata_i[1];
            // counters saturate, clear wins
            if (cnt_clr) begin
                hit_cnt_q <= '0;
            end else if (ctl.hit_evt && (hit_cnt_q != '1)) begin
                hit_cnt_q <= hit_cnt_q + 1'b1;
            end
            if (cnt_clr) begin
                miss_cnt_q <= '0;
            end else if (ctl.miss_evt && (miss_cnt_q != '1)) begin
                miss_cnt_q <= miss_cnt_q + 1'b1;
            end
        end
    end

    // read mux, same cycle
    always_comb begin
        case (csr_addr_i)
            fetch_pkg::CTRL:     csr_rdata_o = {{(`FETCH_WORD_W-1){1'b0}}, en_q};
            fetch_pkg::HIT_CNT:  csr_rdata_o = hit_cnt_q;
            fetch_pkg::MISS_CNT: csr_rdata_o = miss_cnt_q;
            default:             csr_rdata_o = '0;
        endcase
    end

    // icache sees one flush per ctrl write
    a_flush_pulse : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ctl.flush |=> !ctl.flush);

endmodule

// File: fetch_top.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // controller and writeback
    input  logic                     block_if_i,
    input  logic                     inject_nops_i,
    input  logic                     tkbr_i,
    input  logic [`FETCH_ADDR_W-1:0] new_pc_i,
    // toward decode
    output logic                     valid_o,
    output logic [`FETCH_WORD_W-1:0] instr_o,
    output logic [`FETCH_ADDR_W-1:0] pc_o,
    // memory, line refill
    output logic                     mem_rd_o,
    output logic [`FETCH_ADDR_W-1:0] mem_addr_o,
    input  logic                     mem_ready_i,
    input  fetch_pkg::cache_line_t   mem_line_i,
    // control registers
    input  logic                     csr_we_i,
    input  fetch_pkg::csr_addr_e     csr_addr_i,
    input  logic [`FETCH_WORD_W-1:0] csr_wdata_i,
    output logic [`FETCH_WORD_W-1:0] csr_rdata_o
);

    // pc unit <-> cache
    fetch_lookup_if i_lookup_if ();

    // registers <-> cache
    cache_ctl_if i_ctl_if ();

    fetch_pc i_fetch_pc (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .block_if_i   (block_if_i),
        .inject_nops_i(inject_nops_i),
        .tkbr_i       (tkbr_i),
        .new_pc_i     (new_pc_i),
        .lookup       (i_lookup_if.pc),
        .valid_o      (valid_o),
        .instr_o      (instr_o),
        .pc_o         (pc_o)
    );

    icache i_icache (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .lookup     (i_lookup_if.cache),
        .ctl        (i_ctl_if.cache),
        .mem_rd_o   (mem_rd_o),
        .mem_addr_o (mem_addr_o),
        .mem_ready_i(mem_ready_i),
        .mem_line_i (mem_line_i)
    );

    fetch_csr i_fetch_csr (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .csr_we_i   (csr_we_i),
        .csr_addr_i (csr_addr_i),
        .csr_wdata_i(csr_wdata_i),
        .csr_rdata_o(csr_rdata_o),
        .ctl        (i_ctl_if.csr)
    );

endmodule

// File: tb_fetch_checker.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module tb_fetch_checker (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     block_if_i,
    input  logic                     inject_nops_i,
    input  logic                     tkbr_i,
    input  logic [`FETCH_ADDR_W-1:0] new_pc_i,
    input  logic                     valid_o,
    input  logic [`FETCH_WORD_W-1:0] instr_o,
    input  logic [`FETCH_ADDR_W-1:0] pc_o,
    input  logic                     mem_rd_o,
    input  logic [`FETCH_ADDR_W-1:0] mem_addr_o,
    input  logic                     mem_ready_i,
    input  logic [`FETCH_WORD_W-1:0] csr_rdata_o,
    output int                       failed_o
);

    // word at address A holds A xor key
    localparam logic [31:0] WORD_KEY = 32'hA5A50000;

    string cur_name;
    logic [`FETCH_ADDR_W-1:0] exp_pc;
    logic [`FETCH_ADDR_W-1:0] held_pc;
    logic [`FETCH_WORD_W-1:0] held_instr;
    logic [`FETCH_ADDR_W-1:0] req_addr;
    bit req_open;
    bit last_inj;
    bit last_blk;
    int test_errs;
    int pass_cnt;
    int failed_cnt;

    assign failed_o = failed_cnt;

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR %s %s expected %h actual %h", cur_name, what, exp, act);
            test_errs++;
        end
    endtask

    // outputs of the previous edge against the predicted stream
    always @(negedge clk_i) begin
        if (!arst_n_i) begin
            exp_pc = `FETCH_RESET_PC;
            last_inj = 0;
            last_blk = 0;
            req_open = 0;
        end else begin
            if (valid_o && last_blk) begin
                $display("ERROR %s valid output while the stage was blocked", cur_name);
                test_errs++;
            end
            if (last_blk) begin
                // decode side keeps the same word and pc while blocked
                compare("held pc", held_pc, pc_o);
                compare("held instr", held_instr, instr_o);
            end
            if (last_inj && !valid_o) begin
                $display("ERROR %s no valid output after a nop injection", cur_name);
                test_errs++;
            end
            if (valid_o && last_inj) begin
                compare("nop pc", exp_pc, pc_o);
                compare("nop instr", `FETCH_NOP, instr_o);
            end else if (valid_o) begin
                compare("pc", exp_pc, pc_o);
                compare("instr", exp_pc ^ WORD_KEY, instr_o);
                exp_pc = exp_pc + 4;
            end
            // inputs that act on the coming edge
            if (tkbr_i) begin
                exp_pc = new_pc_i;
            end
            last_inj = inject_nops_i && !tkbr_i && !block_if_i;
            last_blk = block_if_i && !tkbr_i;
            held_pc = pc_o;
            held_instr = instr_o;
            // refill request stays up with one line address until the ready pulse
            if (req_open) begin
                if (!mem_rd_o) begin
                    $display("ERROR %s memory read dropped before the ready pulse", cur_name);
                    test_errs++;
                end
                compare("mem addr", req_addr, mem_addr_o);
            end
            if (mem_ready_i) begin
                req_open = 0;
            end else if (mem_rd_o && !req_open) begin
                req_open = 1;
                req_addr = mem_addr_o;
            end
        end
    end

    task automatic begin_test(input string name);
        cur_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test(input bit do_read, input logic [31:0] exp);
        if (do_read) begin
            compare("csr read", exp, csr_rdata_o);
        end
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s ok", cur_name);
        end else begin
            failed_cnt++;
            $display("test %s failed with %0d errors", cur_name, test_errs);
        end
    endtask

    task automatic report();
        $display("tests done: %0d passed, %0d failed", pass_cnt, failed_cnt);
    endtask

endmodule

// File: tb_fetch.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module tb_fetch;

    typedef enum {OP_RUN, OP_BRANCH, OP_BLOCK, OP_INJECT, OP_CSR_WR, OP_CSR_RD} op_e;

    // run counts valid words, block counts cycles
    typedef struct {
        string       name;
        op_e         op;
        logic [31:0] arg;
        int          cycles;
        logic [31:0] exp;
    } row_t;

    logic clk_i;
    logic arst_n_i;
    logic block_if_i;
    logic inject_nops_i;
    logic tkbr_i;
    logic [31:0] new_pc_i;
    logic valid_o;
    logic [31:0] instr_o;
    logic [31:0] pc_o;
    logic mem_rd_o;
    logic [31:0] mem_addr_o;
    logic mem_ready_i;
    logic [127:0] mem_line_i;
    logic csr_we_i;
    fetch_pkg::csr_addr_e csr_addr_i;
    logic [31:0] csr_wdata_i;
    logic [31:0] csr_rdata_o;
    int failed;
    row_t table_q[$];

    fetch_top i_fetch_top (.*);

    tb_fetch_checker i_checker (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .block_if_i(block_if_i),
        .inject_nops_i(inject_nops_i), .tkbr_i(tkbr_i), .new_pc_i(new_pc_i),
        .valid_o(valid_o), .instr_o(instr_o), .pc_o(pc_o),
        .mem_rd_o(mem_rd_o), .mem_addr_o(mem_addr_o), .mem_ready_i(mem_ready_i),
        .csr_rdata_o(csr_rdata_o), .failed_o(failed)
    );

    initial begin
        clk_i = 0;
        forever #10 clk_i = ~clk_i;
    end

    // memory model answering each line request in 1 to 6 cycles
    initial begin
        int lat;
        forever begin
            @(posedge clk_i);
            #3;
            if (mem_rd_o) begin
                lat = 1 + int'($urandom % 6);
                repeat (lat) @(posedge clk_i);
                #3;
                for (int w = 0; w < 4; w++) begin
                    mem_line_i[w*32 +: 32] = (mem_addr_o + 32'(w*4)) ^ 32'hA5A50000;
                end
                mem_ready_i = 1;
                @(posedge clk_i);
                #3 mem_ready_i = 0;
            end
        end
    end

    task automatic add_row(input string name, input op_e op, input logic [31:0] arg,
                           input int cycles, input logic [31:0] exp);
        row_t r;
        r = '{name, op, arg, cycles, exp};
        table_q.push_back(r);
    endtask

    initial begin
        longint limit;
        void'($urandom(32'h6166bf72));
        {block_if_i, inject_nops_i, tkbr_i, mem_ready_i, csr_we_i} = '0;
        block_if_i = 1;
        new_pc_i = 0;
        mem_line_i = 0;
        csr_addr_i = fetch_pkg::CTRL;
        csr_wdata_i = 0;
        arst_n_i = 0;
        add_row("seq_fetch", OP_RUN, 0, 10, 0);
        add_row("branch_redirect", OP_BRANCH, 32'h200, 1, 0);
        add_row("branch_run", OP_RUN, 0, 6, 0);
        add_row("block_hold", OP_BLOCK, 0, 8, 0);
        add_row("block_resume", OP_RUN, 0, 3, 0);
        add_row("inject_nop", OP_INJECT, 0, 1, 0);
        add_row("inject_resume", OP_RUN, 0, 5, 0);
        add_row("flush_clear", OP_CSR_WR, 32'h7, 1, 0);
        add_row("cnt_branch", OP_BRANCH, 32'h100, 1, 0);
        add_row("cnt_fetch", OP_RUN, 0, 16, 0);
        add_row("cnt_miss", OP_CSR_RD, 2, 1, 4);
        add_row("cnt_hit", OP_CSR_RD, 1, 1, 12);
        add_row("refetch_branch", OP_BRANCH, 32'h100, 1, 0);
        add_row("refetch_run", OP_RUN, 0, 16, 0);
        add_row("refetch_hit", OP_CSR_RD, 1, 1, 28);
        add_row("refetch_miss", OP_CSR_RD, 2, 1, 4);
        add_row("refetch_flush", OP_CSR_WR, 32'h3, 1, 0);
        add_row("reflush_branch", OP_BRANCH, 32'h100, 1, 0);
        add_row("reflush_run", OP_RUN, 0, 16, 0);
        add_row("reflush_miss", OP_CSR_RD, 2, 1, 8);
        // with the cache off fetch line a, then line b, then line a again
        add_row("off_clear", OP_CSR_WR, 32'h4, 1, 0);
        add_row("off_branch_a", OP_BRANCH, 32'h300, 1, 0);
        add_row("off_run_a", OP_RUN, 0, 4, 0);
        add_row("off_branch_b", OP_BRANCH, 32'h400, 1, 0);
        add_row("off_run_b", OP_RUN, 0, 4, 0);
        add_row("off_branch_a2", OP_BRANCH, 32'h300, 1, 0);
        add_row("off_run_a2", OP_RUN, 0, 4, 0);
        add_row("off_miss", OP_CSR_RD, 2, 1, 3);
        add_row("off_ctrl", OP_CSR_RD, 0, 1, 0);

        // worst case about nine cycles per table cycle
        limit = 0;
        foreach (table_q[i]) limit += table_q[i].cycles;
        limit = (limit * 9 + 100) * 20;
        fork
            begin
                #(limit);
                $display("timeout: the test table did not finish in %0d ns", limit);
                $display("Simulation FAILED");
                $finish;
            end
        join_none

        repeat (10) @(posedge clk_i);
        #2 arst_n_i = 1;

        foreach (table_q[i]) begin
            i_checker.begin_test(table_q[i].name);
            @(posedge clk_i);
            #2;
            case (table_q[i].op)
                OP_RUN: begin
                    int cnt;
                    cnt = 0;
                    block_if_i = 0;
                    while (cnt < table_q[i].cycles) begin
                        @(posedge clk_i);
                        #2;
                        if (valid_o) cnt++;
                    end
                    // stop before the next lookup counts
                    block_if_i = 1;
                end
                OP_BRANCH: begin
                    tkbr_i = 1;
                    new_pc_i = table_q[i].arg;
                    @(posedge clk_i);
                    #2 tkbr_i = 0;
                end
                OP_BLOCK: repeat (table_q[i].cycles) @(posedge clk_i);
                OP_INJECT: begin
                    block_if_i = 0;
                    inject_nops_i = 1;
                    @(posedge clk_i);
                    #2;
                    inject_nops_i = 0;
                    block_if_i = 1;
                end
                OP_CSR_WR: begin
                    csr_we_i = 1;
                    csr_addr_i = fetch_pkg::CTRL;
                    csr_wdata_i = table_q[i].arg;
                    @(posedge clk_i);
                    #2 csr_we_i = 0;
                end
                default: csr_addr_i = fetch_pkg::csr_addr_e'(table_q[i].arg[1:0]);
            endcase
            @(negedge clk_i);
            #1 i_checker.finish_test(table_q[i].op == OP_CSR_RD, table_q[i].exp);
        end

        i_checker.report();
        if (failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+.
fetch_pkg.sv
fetch_ifs.sv
cache_array.sv
icache.sv
fetch_pc.sv
fetch_csr.sv
fetch_top.sv
tb_fetch_checker.sv
tb_fetch.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= tb_fetch
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
